// File: rtl/pcie_dma_pkg.sv
/*
 * pcie endpoint target, shared definitions
 * sizes, tlp fmt/type codes and the one-beat tlp layout,
 * viewed either as a request or as a completion
 */
`default_nettype none

package pcie_dma_pkg;

    // ********************
    // sizes
    localparam int TLP_W      = 128;
    localparam int DW_W       = 32;
    localparam int BAR_ADDR_W = 6;
    localparam int BAR_DEPTH  = 64;
    localparam int FIFO_DEPTH = 4;

    // ********************
    // header field values
    localparam logic [7:0] FMT_TYPE_MWR32 = 8'h40;
    localparam logic [7:0] FMT_TYPE_MRD32 = 8'h00;
    localparam logic [7:0] FMT_TYPE_CPLD  = 8'h4a;
    localparam logic [2:0] CPL_STATUS_SC  = 3'd0;

    // request view, 3dw header plus one data dw
    typedef struct packed {
        logic [7:0]      fmt_type;
        logic            rsvd0;
        logic [2:0]      tc;
        logic [5:0]      rsvd1;
        logic [1:0]      attr;
        logic [1:0]      rsvd2;
        logic [9:0]      length;
        logic [15:0]     req_id;
        logic [7:0]      tag;
        logic [3:0]      last_be;
        logic [3:0]      first_be;
        // dw address, byte address bits 31..2
        logic [29:0]     addr;
        logic [1:0]      rsvd3;
        logic [DW_W-1:0] data;
    } req_hdr_t;

    // completion view
    typedef struct packed {
        logic [7:0]      fmt_type;
        logic [13:0]     rsvd0;
        logic [9:0]      length;
        logic [15:0]     cpl_id;
        logic [2:0]      status;
        logic            bcm;
        logic [11:0]     byte_cnt;
        logic [15:0]     req_id;
        logic [7:0]      tag;
        logic            rsvd1;
        logic [6:0]      lower_addr;
        logic [DW_W-1:0] data;
    } cpl_hdr_t;

    typedef union packed {
        req_hdr_t req;
        cpl_hdr_t cpl;
    } tlp_beat_u;

endpackage

`default_nettype wire

// File: rtl/dma_ifs.sv
/*
 * internal buses of the endpoint target
 * bar_wr_if: bar memory write port plus combinational read
 * rd_req_if: valid/ready channel of pending read requests
 */
`default_nettype none

interface bar_wr_if import pcie_dma_pkg::*; ();
    logic                  wr_en;
    logic [BAR_ADDR_W-1:0] wr_addr;
    logic [DW_W-1:0]       wr_data;
    logic [3:0]            wr_be;
    logic [BAR_ADDR_W-1:0] rd_addr;
    logic [DW_W-1:0]       rd_data;

    modport master (output wr_en, wr_addr, wr_data, wr_be, rd_addr, input rd_data);
    modport target (input wr_en, wr_addr, wr_data, wr_be, rd_addr, output rd_data);
endinterface

interface rd_req_if import pcie_dma_pkg::*; ();
    logic            vld;
    logic            rdy;
    logic [15:0]     req_id;
    logic [7:0]      tag;
    logic [6:0]      lower_addr;
    logic [DW_W-1:0] data;

    modport source (output vld, req_id, tag, lower_addr, data, input rdy);
    modport sink (input vld, req_id, tag, lower_addr, data, output rdy);
endinterface

`default_nettype wire

// File: rtl/tlp_rx_decoder.sv
/*
 * tlp receive decoder
 * mwr32 beats write the bar memory, mrd32 beats push a read
 * request carrying the current memory dw, all else is dropped
 */
`default_nettype none

module tlp_rx_decoder import pcie_dma_pkg::*;
(
    input  wire            i_axis_tvld,
    output logic           o_axis_trdy,
    input  wire tlp_beat_u i_axis_tdata,

    bar_wr_if.master       bar,
    rd_req_if.source       req
);

    req_hdr_t hdr;
    logic     is_mwr;
    logic     is_mrd;
    logic     accept;

    assign hdr = i_axis_tdata.req;

    // ********************
    // type decode
    // only single-dw requests are handled
    assign is_mwr = (hdr.fmt_type == FMT_TYPE_MWR32) && (hdr.length == 10'd1);
    assign is_mrd = (hdr.fmt_type == FMT_TYPE_MRD32) && (hdr.length == 10'd1);

    // the queue is the only thing that can stall the master stream
    assign o_axis_trdy = req.rdy;
    assign accept      = i_axis_tvld & req.rdy;

    // ********************
    // bar write
    // dw index is byte address bits 7..2
    assign bar.wr_en   = accept & is_mwr;
    assign bar.wr_addr = hdr.addr[BAR_ADDR_W-1:0];
    assign bar.wr_data = hdr.data;
    assign bar.wr_be   = hdr.first_be;

    // read side, same index
    assign bar.rd_addr = hdr.addr[BAR_ADDR_W-1:0];

    // ********************
    // read request push
    // memory dw is sampled before any write of a later beat lands
    assign req.vld        = i_axis_tvld & is_mrd;
    assign req.req_id     = hdr.req_id;
    assign req.tag        = hdr.tag;
    assign req.lower_addr = {hdr.addr[4:0], 2'b00};
    assign req.data       = bar.rd_data;

endmodule

`default_nettype wire

// File: rtl/bar_mem.sv
/*
 * bar memory, 64 dws
 * byte-enabled synchronous write, combinational read
 */
`default_nettype none

module bar_mem import pcie_dma_pkg::*;
(
    input  wire      i_clk,
    bar_wr_if.target bar
);

    logic [DW_W-1:0] mem [BAR_DEPTH];

    // only the enabled byte lanes change
    always_ff @(posedge i_clk)
    begin
        if (bar.wr_en)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (bar.wr_be[b])
                begin
                    mem[bar.wr_addr][b*8 +: 8] <= bar.wr_data[b*8 +: 8];
                end
            end
        end
    end

    assign bar.rd_data = mem[bar.rd_addr];

endmodule

`default_nettype wire

// File: rtl/rd_req_fifo.sv
/*
 * read request queue
 * four-entry circular buffer between decoder and completion builder
 */
`default_nettype none

module rd_req_fifo import pcie_dma_pkg::*;
(
    input  wire      i_clk,
    input  wire      i_rst_n,
    rd_req_if.sink   push,
    rd_req_if.source pop
);

    logic [15:0]     id_mem   [FIFO_DEPTH];
    logic [7:0]      tag_mem  [FIFO_DEPTH];
    logic [6:0]      la_mem   [FIFO_DEPTH];
    logic [DW_W-1:0] data_mem [FIFO_DEPTH];

    logic [$clog2(FIFO_DEPTH)-1:0] wr_ptr;
    logic [$clog2(FIFO_DEPTH)-1:0] rd_ptr;
    logic [$clog2(FIFO_DEPTH):0]   count;
    logic                          push_fire;
    logic                          pop_fire;

    assign push.rdy  = (count != FIFO_DEPTH);
    assign pop.vld   = (count != 0);
    assign push_fire = push.vld & push.rdy;
    assign pop_fire  = pop.vld & pop.rdy;

    // ********************
    // pointers and fill level
    // depth is a power of two so pointers wrap on their own
    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_fire)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop_fire)
                rd_ptr <= rd_ptr + 1'b1;
            if (push_fire && !pop_fire)
                count <= count + 1'b1;
            else if (pop_fire && !push_fire)
                count <= count - 1'b1;
        end
    end

    // entry storage
    always_ff @(posedge i_clk)
    begin
        if (push_fire)
        begin
            id_mem[wr_ptr]   <= push.req_id;
            tag_mem[wr_ptr]  <= push.tag;
            la_mem[wr_ptr]   <= push.lower_addr;
            data_mem[wr_ptr] <= push.data;
        end
    end

    assign pop.req_id     = id_mem[rd_ptr];
    assign pop.tag        = tag_mem[rd_ptr];
    assign pop.lower_addr = la_mem[rd_ptr];
    assign pop.data       = data_mem[rd_ptr];

endmodule

`default_nettype wire

// File: rtl/cpl_tx_builder.sv
/*
 * completion builder
 * turns a queued read request into a one-beat cpld and holds it
 * in an output register until the slave stream takes it
 */
`default_nettype none

module cpl_tx_builder import pcie_dma_pkg::*;
(
    input  wire        i_clk,
    input  wire        i_rst_n,
    input  wire [7:0]  i_cfg_pbus_num,
    input  wire [4:0]  i_cfg_pbus_dev_num,

    rd_req_if.sink     req,

    output logic       o_axis_tvld,
    input  wire        i_axis_trdy,
    output tlp_beat_u  o_axis_tdata,
    output logic       o_axis_tlast
);

    cpl_hdr_t  cpl_next;
    tlp_beat_u out_beat;
    logic      out_vld;
    logic      load;

    // ********************
    // completion fields
    always_comb
    begin
        cpl_next            = '0;
        cpl_next.fmt_type   = FMT_TYPE_CPLD;
        cpl_next.length     = 10'd1;
        // function number is always 0
        cpl_next.cpl_id     = {i_cfg_pbus_num, i_cfg_pbus_dev_num, 3'b000};
        cpl_next.status     = CPL_STATUS_SC;
        cpl_next.byte_cnt   = 12'd4;
        cpl_next.req_id     = req.req_id;
        cpl_next.tag        = req.tag;
        cpl_next.lower_addr = req.lower_addr;
        cpl_next.data       = req.data;
    end

    // ********************
    // output register
    // pop when empty or when the held beat leaves this cycle
    assign req.rdy = !out_vld || i_axis_trdy;
    assign load    = req.vld & req.rdy;

    always_ff @(posedge i_clk or negedge i_rst_n)
    begin
        if (!i_rst_n)
            out_vld <= 1'b0;
        else if (req.rdy)
            out_vld <= req.vld;
    end

    always_ff @(posedge i_clk)
    begin
        if (load)
            out_beat.cpl <= cpl_next;
    end

    assign o_axis_tvld  = out_vld;
    assign o_axis_tdata = out_beat;
    // every tlp is a single beat
    assign o_axis_tlast = out_vld;

endmodule

`default_nettype wire

// File: rtl/pcie_dma_top.sv
/*
 * pcie endpoint target top
 * tlp decoder, bar memory, read request queue and completion builder
 */
`default_nettype none

module pcie_dma_top import pcie_dma_pkg::*;
(
    input  wire              i_clk,
    input  wire              i_rst_n,

    input  wire [7:0]        i_cfg_pbus_num,
    input  wire [4:0]        i_cfg_pbus_dev_num,

    // ********************
    // axis master, tlps toward the endpoint
    input  wire              i_axis_master_tvld,
    output logic             o_axis_master_trdy,
    input  wire [TLP_W-1:0]  i_axis_master_tdata,

    // axis slave, completions out
    output logic             o_axis_slave_tvld,
    input  wire              i_axis_slave_trdy,
    output logic [TLP_W-1:0] o_axis_slave_tdata,
    output logic             o_axis_slave_tlast
);

    bar_wr_if bar_bus ();
    rd_req_if req_q ();
    rd_req_if cpl_req ();

    tlp_rx_decoder u_tlp_rx_decoder (
        .i_axis_tvld  (i_axis_master_tvld),
        .o_axis_trdy  (o_axis_master_trdy),
        .i_axis_tdata (i_axis_master_tdata),
        .bar          (bar_bus.master),
        .req          (req_q.source)
    );

    bar_mem u_bar_mem (
        .i_clk (i_clk),
        .bar   (bar_bus.target)
    );

    rd_req_fifo u_rd_req_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .push    (req_q.sink),
        .pop     (cpl_req.source)
    );

    cpl_tx_builder u_cpl_tx_builder (
        .i_clk              (i_clk),
        .i_rst_n            (i_rst_n),
        .i_cfg_pbus_num     (i_cfg_pbus_num),
        .i_cfg_pbus_dev_num (i_cfg_pbus_dev_num),
        .req                (cpl_req.sink),
        .o_axis_tvld        (o_axis_slave_tvld),
        .i_axis_trdy        (i_axis_slave_trdy),
        .o_axis_tdata       (o_axis_slave_tdata),
        .o_axis_tlast       (o_axis_slave_tlast)
    );

endmodule

`default_nettype wire

// File: test/tb_pcie_dma.sv
/*
 * testbench for the pcie endpoint target
 * random mwr32/mrd32/other beats from an xorshift generator,
 * a bar memory model and an expected completion queue
 */
`default_nettype none

module tb_pcie_dma import pcie_dma_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD = 40;
    localparam int N_RAND     = 400;
    localparam int N_BEATS    = BAR_DEPTH + N_RAND + 6 + BAR_DEPTH;
    localparam logic [31:0] SEED = 32'ha3072375;

    logic        clk;
    logic        rst_n;
    logic [7:0]  cfg_bus;
    logic [4:0]  cfg_dev;
    logic        m_tvld;
    logic        m_trdy;
    tlp_beat_u   m_tdata;
    logic        s_tvld;
    logic        s_trdy;
    logic        s_tlast;
    tlp_beat_u   s_tdata;

    logic [31:0] stim_st;
    logic [31:0] rdy_st;
    logic        hold_low;
    int          err_cnt;
    int          other_cnt;

    // reference model
    logic [DW_W-1:0] model_mem [BAR_DEPTH];
    tlp_beat_u       exp_q[$];

    pcie_dma_top dut0 (
        .i_clk               (clk),
        .i_rst_n             (rst_n),
        .i_cfg_pbus_num      (cfg_bus),
        .i_cfg_pbus_dev_num  (cfg_dev),
        .i_axis_master_tvld  (m_tvld),
        .o_axis_master_trdy  (m_trdy),
        .i_axis_master_tdata (m_tdata),
        .o_axis_slave_tvld   (s_tvld),
        .i_axis_slave_trdy   (s_trdy),
        .o_axis_slave_tdata  (s_tdata),
        .o_axis_slave_tlast  (s_tlast)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_stim();
        stim_st = xorshift32(stim_st);
        return stim_st;
    endfunction

    function automatic tlp_beat_u make_req(input logic [7:0] ft, input logic [29:0] addr,
                                           input logic [3:0] be, input logic [31:0] data);
        tlp_beat_u   b;
        logic [31:0] r;
        r = next_stim();
        b = '0;
        b.req.fmt_type = ft;
        b.req.length   = 10'd1;
        b.req.req_id   = r[15:0];
        b.req.tag      = r[23:16];
        b.req.first_be = be;
        b.req.addr     = addr;
        b.req.data     = data;
        return b;
    endfunction

    // ********************
    // compare tasks
    task automatic check_cpl(input tlp_beat_u act, input tlp_beat_u exp);
        if (act !== exp)
        begin
            err_cnt++;
            $display("** Error at %0d ns: completion tag %h got %h expected %h",
                     $time, exp.cpl.tag, act, exp);
        end
    endtask

    task automatic check_flag(input logic act, input logic exp, input string what);
        if (act !== exp)
        begin
            err_cnt++;
            $display("** Error at %0d ns: %s is %b, expected %b", $time, what, act, exp);
        end
    endtask

    // model update on an accepted master beat
    task automatic model_accept(input tlp_beat_u b);
        req_hdr_t    r;
        tlp_beat_u   e;
        logic [31:0] byte_addr;
        r         = b.req;
        byte_addr = {r.addr, 2'b00};
        if (r.fmt_type == FMT_TYPE_MWR32 && r.length == 10'd1)
        begin
            for (int i = 0; i < 4; i++)
                if (r.first_be[i])
                    model_mem[byte_addr[7:2]][i*8 +: 8] = r.data[i*8 +: 8];
        end
        else if (r.fmt_type == FMT_TYPE_MRD32 && r.length == 10'd1)
        begin
            e = '0;
            e.cpl.fmt_type   = FMT_TYPE_CPLD;
            e.cpl.length     = 10'd1;
            e.cpl.cpl_id     = {cfg_bus, cfg_dev, 3'b000};
            e.cpl.status     = CPL_STATUS_SC;
            e.cpl.byte_cnt   = 12'd4;
            e.cpl.req_id     = r.req_id;
            e.cpl.tag        = r.tag;
            e.cpl.lower_addr = byte_addr[6:0] & 7'h7c;
            e.cpl.data       = model_mem[byte_addr[7:2]];
            exp_q.push_back(e);
        end
    endtask

    // ********************
    // monitors
    always @(posedge clk)
    begin
        if (rst_n && s_tvld && s_trdy)
        begin
            if (exp_q.size() == 0)
            begin
                other_cnt++;
                $display("a completion came out with no read request waiting for it");
            end
            else
            begin
                check_cpl(s_tdata, exp_q.pop_front());
                check_flag(s_tlast, 1'b1, "tlast");
            end
        end
        if (rst_n && m_tvld && m_trdy)
            model_accept(m_tdata);
    end

    // slave ready is random unless held low
    always @(negedge clk)
    begin
        rdy_st = xorshift32(rdy_st);
        s_trdy = hold_low ? 1'b0 : rdy_st[0];
    end

    task automatic send_beat(input tlp_beat_u b);
        @(negedge clk);
        m_tvld  = 1'b1;
        m_tdata = b;
        do
            @(posedge clk);
        while (!m_trdy);
    endtask

    task automatic drain();
        @(negedge clk);
        m_tvld = 1'b0;
        while (exp_q.size() != 0)
            @(negedge clk);
    endtask

    initial
    begin
        #(CLK_PERIOD * 20 * N_BEATS);
        $display("timeout: the run did not finish in time");
        $display("Test failed");
        $finish;
    end

    initial
    begin
        tlp_beat_u   cur;
        logic [31:0] r;
        logic [7:0]  ft;
        int          acc;
        logic        need_new;

        clk       = 1'b0;
        rst_n     = 1'b0;
        cfg_bus   = 8'h5c;
        cfg_dev   = 5'h13;
        m_tvld    = 1'b0;
        m_tdata   = '0;
        s_trdy    = 1'b0;
        hold_low  = 1'b0;
        stim_st   = SEED;
        rdy_st    = ~SEED;
        err_cnt   = 0;
        other_cnt = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        @(negedge clk);
        check_flag(s_tvld, 1'b0, "slave tvld after reset");
        check_flag(m_trdy, 1'b1, "master trdy after reset");

        // full write of every dw with junk in the upper address bits
        for (int i = 0; i < BAR_DEPTH; i++)
        begin
            r = next_stim();
            send_beat(make_req(FMT_TYPE_MWR32, {r[23:0], 6'(i)}, 4'hf, next_stim()));
        end

        // random mix of writes, reads and other types
        for (int i = 0; i < N_RAND; i++)
        begin
            r = next_stim();
            case (r[1:0])
                2'd0:    ft = FMT_TYPE_MWR32;
                2'd3:    ft = r[15:8];
                default: ft = FMT_TYPE_MRD32;
            endcase
            if (r[1:0] == 2'd3 && (ft == FMT_TYPE_MWR32 || ft == FMT_TYPE_MRD32))
                ft = 8'h20;
            send_beat(make_req(ft, r[31:2], r[19:16], next_stim()));
        end
        drain();

        // back-pressure leaves room for four queued and one held
        @(posedge clk);
        hold_low = 1'b1;
        acc      = 0;
        need_new = 1'b1;
        for (int cyc = 0; cyc < 20; cyc++)
        begin
            @(negedge clk);
            if (need_new)
            begin
                r   = next_stim();
                cur = make_req(FMT_TYPE_MRD32, r[31:2], 4'hf, 32'h0);
            end
            need_new = 1'b0;
            m_tvld   = 1'b1;
            m_tdata  = cur;
            @(posedge clk);
            if (m_trdy)
            begin
                acc++;
                need_new = 1'b1;
            end
        end
        check_flag(acc == 5, 1'b1, $sformatf("%0d mrd beats accepted, 5 in flight", acc));
        @(negedge clk);
        check_flag(m_trdy, 1'b0, "master trdy while slave is stalled");
        @(posedge clk);
        hold_low = 1'b0;
        if (!need_new)
            do
                @(posedge clk);
            while (!m_trdy);

        // read back the whole memory
        for (int i = 0; i < BAR_DEPTH; i++)
            send_beat(make_req(FMT_TYPE_MRD32, 30'(i), 4'hf, 32'h0));
        drain();
        repeat (10) @(posedge clk);

        $display("%0d value errors, %0d other failures", err_cnt, other_cnt);
        if (err_cnt == 0 && other_cnt == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
rtl/pcie_dma_pkg.sv
rtl/dma_ifs.sv
rtl/tlp_rx_decoder.sv
rtl/bar_mem.sv
rtl/rd_req_fifo.sv
rtl/cpl_tx_builder.sv
rtl/pcie_dma_top.sv
test/tb_pcie_dma.sv

// File: Bender.yml
package:
  name: pcie_dma

sources:
  - rtl/pcie_dma_pkg.sv
  - rtl/dma_ifs.sv
  - rtl/tlp_rx_decoder.sv
  - rtl/bar_mem.sv
  - rtl/rd_req_fifo.sv
  - rtl/cpl_tx_builder.sv
  - rtl/pcie_dma_top.sv
  - target: test
    files:
      - test/tb_pcie_dma.sv
